// File: Bender.yml
package:
  name: pcs_error

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pcs_pkg.sv
      - rtl/coded_block_if.sv
      - rtl/prbs_bit.sv
      - rtl/block_formatter.sv
      - rtl/block_delay_line.sv
      - rtl/sh_breaker.sv
      - rtl/pcs_error_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verif/tb_pcs_error.sv

// File: rtl/block_delay_line.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcs_settings.svh"

module block_delay_line
(
        input  wire             i_clock,
        input  wire             i_reset,
        coded_block_if.sink     i_block,
        coded_block_if.source   o_block
);
        import pcs_pkg::*;

        localparam int DEPTH = `PCS_DELAY_DEPTH;

        logic [DEPTH-1:0]       valid_pipe;
        logic [DEPTH-1:0]       tag_pipe;
        coded_block_t           block_pipe [DEPTH];

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        valid_pipe <= '0;
                else
                begin
                        valid_pipe[0] <= i_block.valid;
                        for (int i = 1; i < DEPTH; i++)
                                valid_pipe[i] <= valid_pipe[i-1];
                end
        end

        // Block contents shift every cycle, valid says which ones count
        always_ff @(posedge i_clock)
        begin
                tag_pipe[0]   <= i_block.aligner_tag;
                block_pipe[0] <= {i_block.sync_header, i_block.payload};
                for (int i = 1; i < DEPTH; i++)
                begin
                        tag_pipe[i]   <= tag_pipe[i-1];
                        block_pipe[i] <= block_pipe[i-1];
                end
        end

        assign o_block.valid       = valid_pipe[DEPTH-1];
        assign o_block.aligner_tag = tag_pipe[DEPTH-1];
        assign o_block.sync_header = block_pipe[DEPTH-1].sync_header;
        assign o_block.payload     = block_pipe[DEPTH-1].payload;

        a_fixed_latency: assert property (@(posedge i_clock) disable iff (i_reset)
                o_block.valid == $past(i_block.valid, DEPTH));

endmodule

`default_nettype wire

// File: rtl/block_formatter.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcs_settings.svh"

module block_formatter
(
        input  wire                     i_clock,
        input  wire                     i_reset,
        input  wire                     i_valid,
        input  wire                     i_ctrl,         // High for a control block
        input  wire pcs_pkg::payload_t  i_payload,
        coded_block_if.source           o_block
);
        import pcs_pkg::*;

        localparam int NB_ALIGN_CNT = $clog2(`PCS_ALIGN_PERIOD);
        localparam logic [NB_ALIGN_CNT-1:0] ALIGN_LAST = NB_ALIGN_CNT'(`PCS_ALIGN_PERIOD - 1);

        logic [NB_ALIGN_CNT-1:0]        align_cnt;
        logic                           align_hit;

        // Zero count marks the next aligner block
        assign align_hit = (align_cnt == '0);

        // Counts valid blocks only so gaps leave it alone
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        align_cnt <= '0;
                else if (i_valid)
                begin
                        if (align_cnt == ALIGN_LAST)
                                align_cnt <= '0;
                        else
                                align_cnt <= align_cnt + 1'b1;
                end
        end

        // Qualifiers
        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        o_block.valid       <= 1'b0;
                        o_block.aligner_tag <= 1'b0;
                end
                else
                begin
                        o_block.valid       <= i_valid;
                        o_block.aligner_tag <= i_valid & align_hit;
                end
        end

        // Header and payload load only with a block
        always_ff @(posedge i_clock)
        begin
                if (i_valid)
                begin
                        o_block.sync_header <= i_ctrl ? SH_CTRL : SH_DATA;
                        o_block.payload     <= i_payload;
                end
        end

        a_tag_with_valid: assert property (@(posedge i_clock) disable iff (i_reset)
                o_block.aligner_tag |-> o_block.valid ##1 !o_block.aligner_tag);

endmodule

`default_nettype wire

// File: rtl/coded_block_if.sv
`timescale 1ns/10ps
`default_nettype none

// One coded block per cycle, qualified by valid
interface coded_block_if;
        import pcs_pkg::*;

        logic           valid;
        sync_header_t   sync_header;
        payload_t       payload;
        logic           aligner_tag;    // Marks an aligner position

        modport source
        (
                output valid,
                output sync_header,
                output payload,
                output aligner_tag
        );

        modport sink
        (
                input  valid,
                input  sync_header,
                input  payload,
                input  aligner_tag
        );

endinterface

`default_nettype wire

// File: rtl/pcs_error_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcs_settings.svh"

module pcs_error_top
(
        input  wire                             i_clock,
        input  wire                             i_reset,
        input  wire                             i_valid,
        input  wire                             i_ctrl,
        input  wire pcs_pkg::payload_t          i_payload,
        input  wire                             i_rf_update,
        input  wire pcs_pkg::err_mode_t         i_rf_mode,
        input  wire [`PCS_NB_BURST-1:0]         i_rf_error_burst,
        input  wire [`PCS_NB_PERIOD-1:0]        i_rf_error_period,
        input  wire [`PCS_NB_REPEAT-1:0]        i_rf_error_repeat,
        output logic                            o_valid,
        output pcs_pkg::coded_block_t           o_data,
        output logic                            o_aligner_tag
);

        coded_block_if fmt_block ();    // Formatter to delay line
        coded_block_if dly_block ();    // Delay line to breaker

        block_formatter u_formatter
        (
                .i_clock                (i_clock),
                .i_reset                (i_reset),
                .i_valid                (i_valid),
                .i_ctrl                 (i_ctrl),
                .i_payload              (i_payload),
                .o_block                (fmt_block.source)
        );

        block_delay_line u_delay_line
        (
                .i_clock                (i_clock),
                .i_reset                (i_reset),
                .i_block                (fmt_block.sink),
                .o_block                (dly_block.source)
        );

        sh_breaker u_breaker
        (
                .i_clock                (i_clock),
                .i_reset                (i_reset),
                .i_block                (dly_block.sink),
                .i_rf_update            (i_rf_update),
                .i_rf_mode              (i_rf_mode),
                .i_rf_error_burst       (i_rf_error_burst),
                .i_rf_error_period      (i_rf_error_period),
                .i_rf_error_repeat      (i_rf_error_repeat),
                .o_valid                (o_valid),
                .o_data                 (o_data),
                .o_aligner_tag          (o_aligner_tag)
        );

endmodule

`default_nettype wire

// File: rtl/pcs_pkg.sv
`default_nettype none

package pcs_pkg;

        // 64b/66b block fields
        typedef logic [1:0]     sync_header_t;
        typedef logic [63:0]    payload_t;

        // Header sits in the two upper bits of the 66-bit block
        typedef struct packed
        {
                sync_header_t   sync_header;
                payload_t       payload;
        } coded_block_t;

        // Breaker block selection, one-hot
        typedef enum logic [3:0]
        {
                MODE_ALIGN      = 4'b0001,      // Aligner-tagged blocks only
                MODE_CTRL       = 4'b0010,
                MODE_DATA       = 4'b0100,
                MODE_ALL        = 4'b1000
        } err_mode_t;

        // Valid sync headers
        localparam sync_header_t SH_DATA = 2'b01;
        localparam sync_header_t SH_CTRL = 2'b10;

        // 00 and 11 are never produced by a healthy transmitter

endpackage

`default_nettype wire

// File: rtl/pcs_settings.svh
`ifndef PCS_SETTINGS_SVH
`define PCS_SETTINGS_SVH

// Valid blocks from one aligner marker to the next
`define PCS_ALIGN_PERIOD        16

`define PCS_DELAY_DEPTH         4       // Lane path stages ahead of the breaker

// Breaker counter widths
`define PCS_NB_BURST            10
`define PCS_NB_PERIOD           10
`define PCS_NB_REPEAT           4

// Starting state of the breaker PRBS, must not be zero
`define PCS_PRBS_SEED           9'h1a5

`endif

// File: rtl/prbs_bit.sv
`timescale 1ns/10ps
`default_nettype none

// x^9 + x^5 + 1 sequence, one bit per enabled cycle
module prbs_bit
#(
        parameter logic [8:0] SEED = 9'h1ff
)
(
        input  wire     i_clock,
        input  wire     i_reset,
        input  wire     i_enable,
        output logic    o_bit
);

        logic [8:0]     lfsr;
        logic           feedback;

        assign feedback = lfsr[8] ^ lfsr[4];    // Taps 9 and 5

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        lfsr <= SEED;
                else if (i_enable)
                        lfsr <= {lfsr[7:0], feedback};
        end

        assign o_bit = lfsr[8];

        // A zero state would lock the sequence for good
        a_lfsr_not_zero: assert property (@(posedge i_clock) disable iff (i_reset)
                lfsr != '0);

endmodule

`default_nettype wire

// File: rtl/sh_breaker.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcs_settings.svh"

module sh_breaker
(
        input  wire                             i_clock,
        input  wire                             i_reset,
        coded_block_if.sink                     i_block,
        input  wire                             i_rf_update,        // Loads the new setup
        input  wire pcs_pkg::err_mode_t         i_rf_mode,
        input  wire [`PCS_NB_BURST-1:0]         i_rf_error_burst,   // Broken blocks per period
        input  wire [`PCS_NB_PERIOD-1:0]        i_rf_error_period,  // Valid blocks per period
        input  wire [`PCS_NB_REPEAT-1:0]        i_rf_error_repeat,  // Extra periods
        output logic                            o_valid,
        output pcs_pkg::coded_block_t           o_data,
        output logic                            o_aligner_tag
);
        import pcs_pkg::*;

        // Stored setup
        err_mode_t                      mode;
        logic [`PCS_NB_BURST-1:0]       cfg_burst;
        logic [`PCS_NB_PERIOD-1:0]      cfg_period;

        logic [`PCS_NB_BURST-1:0]       burst_cnt;
        logic [`PCS_NB_PERIOD-1:0]      period_cnt;
        logic [`PCS_NB_REPEAT-1:0]      repeat_cnt;

        logic                           burst_on;
        logic                           period_on;
        logic                           repeat_on;
        logic                           reload;
        logic                           eligible;
        logic                           break_now;
        logic                           prbs_out;
        sync_header_t                   err_sh;

        assign burst_on  = (burst_cnt != '0);
        assign period_on = (period_cnt != '0);
        assign repeat_on = (repeat_cnt != '0);

        // Period over with repeats left restarts from the stored setup
        assign reload = !period_on && repeat_on;

        always_comb
        begin
                case (mode)
                MODE_ALIGN:     eligible = i_block.aligner_tag;
                MODE_CTRL:      eligible = (i_block.sync_header == SH_CTRL);
                MODE_DATA:      eligible = (i_block.sync_header == SH_DATA);
                MODE_ALL:       eligible = 1'b1;
                default:        eligible = 1'b0;        // Not one-hot
                endcase
        end

        // Update and reload cycles never break
        assign break_now = i_block.valid && eligible && burst_on && !reload && !i_rf_update;

        assign err_sh = prbs_out ? 2'b11 : 2'b00;

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                begin
                        mode       <= MODE_ALL;
                        cfg_burst  <= '0;
                        cfg_period <= '0;
                        burst_cnt  <= '0;
                        period_cnt <= '0;
                        repeat_cnt <= '0;
                end
                else if (i_rf_update)
                begin
                        mode       <= i_rf_mode;
                        cfg_burst  <= i_rf_error_burst;
                        cfg_period <= i_rf_error_period;
                        burst_cnt  <= i_rf_error_burst;
                        period_cnt <= i_rf_error_period;
                        repeat_cnt <= i_rf_error_repeat;
                end
                else if (reload)
                begin
                        burst_cnt  <= cfg_burst;
                        period_cnt <= cfg_period;
                        repeat_cnt <= repeat_cnt - 1'b1;
                end
                else
                begin
                        if (i_block.valid && period_on)
                                period_cnt <= period_cnt - 1'b1;
                        if (break_now)
                                burst_cnt <= burst_cnt - 1'b1;
                end
        end

        // Advances once per valid block
        prbs_bit
        #(
                .SEED           (`PCS_PRBS_SEED)
        )
        u_prbs
        (
                .i_clock        (i_clock),
                .i_reset        (i_reset),
                .i_enable       (i_block.valid),
                .o_bit          (prbs_out)
        );

        always_ff @(posedge i_clock)
        begin
                if (i_reset)
                        o_valid <= 1'b0;
                else
                        o_valid <= i_block.valid;
        end

        // Payload and tag are never touched
        always_ff @(posedge i_clock)
        begin
                o_data.sync_header <= break_now ? err_sh : i_block.sync_header;
                o_data.payload     <= i_block.payload;
                o_aligner_tag      <= i_block.aligner_tag;
        end

        // A 00 or 11 header at the output only comes from breaking
        a_broken_header: assert property (@(posedge i_clock) disable iff (i_reset)
                o_valid && (o_data.sync_header inside {2'b00, 2'b11}) |-> $past(break_now));

        a_idle_after_reset: assert property (@(posedge i_clock)
                i_reset |=> !o_valid [*2]);

endmodule

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/pcs_pkg.sv
rtl/coded_block_if.sv
rtl/prbs_bit.sv
rtl/block_formatter.sv
rtl/block_delay_line.sv
rtl/sh_breaker.sv
rtl/pcs_error_top.sv
verif/tb_pcs_error.sv

// File: verif/pcs_testdata.txt
# T name | C mode(hex) burst period repeat | B valid ctrl payload count | E
# Payload R takes the next LCG value, a hex payload repeats as given
T pass_through
B 1 0 0123456789abcdef 1
B 1 1 R 4
B 0 0 0 2
B 1 0 R 33
B 0 0 0 6
E
T all_burst3_period8
C 8 3 8 2
B 1 1 R 28
B 0 0 0 6
E
T ctrl_only
C 2 2 6 1
B 1 0 R 2
B 1 1 R 1
B 1 0 R 1
B 1 1 R 3
B 1 0 R 4
B 1 1 R 2
B 0 0 0 6
E
T data_only
C 4 2 5 1
B 1 1 R 2
B 1 0 R 1
B 1 1 R 2
B 1 0 R 4
B 1 1 R 1
B 0 0 0 6
E
T align_only
C 1 2 40 0
B 1 0 R 36
B 0 0 0 6
E
T gaps_mid_period
C 8 4 6 1
B 1 0 R 2
B 0 0 0 3
B 1 1 R 1
B 0 0 0 1
B 1 0 R 9
B 0 0 0 6
E
T mode_not_onehot
C 3 5 5 0
B 1 1 R 4
B 1 0 R 4
B 0 0 0 6
E

// File: verif/tb_pcs_error.sv
`timescale 1ns/10ps
`default_nettype none

`include "pcs_settings.svh"

module tb_pcs_error;
        import pcs_pkg::*;

        localparam int DEPTH   = `PCS_DELAY_DEPTH;
        localparam int LATENCY = DEPTH + 2;     // Formatter, delay line, breaker

        // One block as it travels towards the breaker
        typedef struct packed
        {
                logic           valid;
                logic           tag;
                coded_block_t   blk;
        } stage_t;

        typedef struct
        {
                int             due;            // Output cycle of the block
                coded_block_t   blk;
                logic           tag;
                logic           broken;
        } expect_t;

        logic                           i_clock;
        logic                           i_reset;
        logic                           i_valid;
        logic                           i_ctrl;
        payload_t                       i_payload;
        logic                           i_rf_update;
        err_mode_t                      i_rf_mode;
        logic [`PCS_NB_BURST-1:0]       i_rf_error_burst;
        logic [`PCS_NB_PERIOD-1:0]      i_rf_error_period;
        logic [`PCS_NB_REPEAT-1:0]      i_rf_error_repeat;
        logic                           o_valid;
        coded_block_t                   o_data;
        logic                           o_aligner_tag;

        // Reference model state
        stage_t                         pipe [DEPTH+1];
        expect_t                        exp_q [$];
        int                             align_cnt;
        err_mode_t                      m_mode;
        logic [`PCS_NB_BURST-1:0]       m_cfg_burst;
        logic [`PCS_NB_PERIOD-1:0]      m_cfg_period;
        logic [`PCS_NB_BURST-1:0]       m_burst;
        logic [`PCS_NB_PERIOD-1:0]      m_period;
        logic [`PCS_NB_REPEAT-1:0]      m_repeat;

        logic [63:0]                    rng_state;
        int                             cyc;
        int                             wd_cnt;
        int                             cycle_limit;
        string                          test_name;
        int                             test_checks;
        int                             test_errors;
        int                             total_checks;
        int                             total_errors;
        int                             n_tests;

        pcs_error_top dut0
        (
                .i_clock                (i_clock),
                .i_reset                (i_reset),
                .i_valid                (i_valid),
                .i_ctrl                 (i_ctrl),
                .i_payload              (i_payload),
                .i_rf_update            (i_rf_update),
                .i_rf_mode              (i_rf_mode),
                .i_rf_error_burst       (i_rf_error_burst),
                .i_rf_error_period      (i_rf_error_period),
                .i_rf_error_repeat      (i_rf_error_repeat),
                .o_valid                (o_valid),
                .o_data                 (o_data),
                .o_aligner_tag          (o_aligner_tag)
        );

        always #2 i_clock = ~i_clock;   // 4 ns period

        always @(posedge i_clock)
        begin
                wd_cnt <= wd_cnt + 1;
                if (cycle_limit > 0 && wd_cnt >= cycle_limit)
                begin
                        $display("Timeout after %0d cycles, the run did not complete", wd_cnt);
                        $display("TESTS FAILED");
                        $finish;
                end
        end

        function automatic logic [63:0] lcg_next(input logic [63:0] state);
                return state * 64'd6364136223846793005 + 64'd1442695040888963407;
        endfunction

        function automatic logic eligible_for_mode(input err_mode_t md, input logic tag,
                                                   input sync_header_t sh);
                case (md)
                MODE_ALIGN:     return tag;
                MODE_CTRL:      return sh == SH_CTRL;
                MODE_DATA:      return sh == SH_DATA;
                MODE_ALL:       return 1'b1;
                default:        return 1'b0;
                endcase
        endfunction

        task automatic report_error(input string msg);
                $display("%s: %s", test_name, msg);
                test_errors++;
        endtask

        task automatic check_block(input coded_block_t exp, input coded_block_t act);
                test_checks++;
                if (act !== exp)
                begin
                        $display("CHECK FAILED %s: block expected %h actual %h",
                                 test_name, exp, act);
                        test_errors++;
                end
        endtask

        task automatic check_broken(input coded_block_t exp, input coded_block_t act);
                test_checks++;
                if (act.payload !== exp.payload || !(act.sync_header inside {2'b00, 2'b11}))
                begin
                        $display("CHECK FAILED %s: broken expected 00/11 payload %h actual %h",
                                 test_name, exp.payload, act);
                        test_errors++;
                end
        endtask

        task automatic check_tag(input logic exp, input logic act);
                if (act !== exp)
                begin
                        $display("CHECK FAILED %s: aligner tag expected %b actual %b",
                                 test_name, exp, act);
                        test_errors++;
                end
        endtask

        // Output during the current cycle against the queue
        task automatic check_output();
                expect_t        e;

                if (exp_q.size() != 0 && exp_q[0].due == cyc)
                begin
                        e = exp_q.pop_front();
                        if (o_valid !== 1'b1)
                                report_error("an expected block did not appear at the output");
                        else
                        begin
                                if (e.broken)
                                        check_broken(e.blk, o_data);
                                else
                                        check_block(e.blk, o_data);
                                check_tag(e.tag, o_aligner_tag);
                        end
                end
                else if (o_valid !== 1'b0)
                        report_error("output valid was high with no block expected");
        endtask

        // Drives one cycle, steps the model, checks at the falling edge
        task automatic run_cycle(input logic v, input logic c, input payload_t pl,
                                 input logic upd, input err_mode_t md,
                                 input logic [`PCS_NB_BURST-1:0] b,
                                 input logic [`PCS_NB_PERIOD-1:0] p,
                                 input logic [`PCS_NB_REPEAT-1:0] r);
                stage_t         in_stage;
                stage_t         new_stage;
                expect_t        e;
                logic           reload;
                logic           brk;

                @(posedge i_clock);
                i_valid           <= v;
                i_ctrl            <= c;
                i_payload         <= pl;
                i_rf_update       <= upd;
                i_rf_mode         <= md;
                i_rf_error_burst  <= b;
                i_rf_error_period <= p;
                i_rf_error_repeat <= r;
                cyc++;

                new_stage.valid = v;
                new_stage.tag   = v && (align_cnt == 0);        // Blocks 1, 17, 33 ...
                new_stage.blk   = {(c ? SH_CTRL : SH_DATA), pl};
                if (v)
                        align_cnt = (align_cnt + 1) % `PCS_ALIGN_PERIOD;

                in_stage = pipe[DEPTH];         // Block at the breaker input now
                for (int i = DEPTH; i > 0; i--)
                        pipe[i] = pipe[i-1];
                pipe[0] = new_stage;

                reload = (m_period == '0) && (m_repeat != '0);
                brk    = in_stage.valid && (m_burst != '0) && !reload && !upd &&
                         eligible_for_mode(m_mode, in_stage.tag, in_stage.blk.sync_header);
                if (in_stage.valid)
                begin
                        e.due    = cyc + 1;
                        e.blk    = in_stage.blk;
                        e.tag    = in_stage.tag;
                        e.broken = brk;
                        exp_q.push_back(e);
                end

                if (upd)
                begin
                        m_mode       = md;
                        m_cfg_burst  = b;
                        m_cfg_period = p;
                        m_burst      = b;
                        m_period     = p;
                        m_repeat     = r;
                end
                else if (reload)
                begin
                        m_burst  = m_cfg_burst;
                        m_period = m_cfg_period;
                        m_repeat = m_repeat - 1'b1;
                end
                else
                begin
                        if (in_stage.valid && m_period != '0)
                                m_period = m_period - 1'b1;
                        if (brk)
                                m_burst = m_burst - 1'b1;
                end

                @(negedge i_clock);
                check_output();
        endtask

        initial
        begin
                int                             fd;
                int                             n;
                int                             stim_cycles;
                string                          line;
                string                          kind;
                string                          tok;
                logic                           v;
                logic                           c;
                logic [3:0]                     md;
                logic [`PCS_NB_BURST-1:0]       b;
                logic [`PCS_NB_PERIOD-1:0]      p;
                logic [`PCS_NB_REPEAT-1:0]      r;
                payload_t                       pl;

                i_clock           = 1'b0;
                i_reset           = 1'b1;
                i_valid           = 1'b0;
                i_ctrl            = 1'b0;
                i_payload         = '0;
                i_rf_update       = 1'b0;
                i_rf_mode         = MODE_ALL;
                i_rf_error_burst  = '0;
                i_rf_error_period = '0;
                i_rf_error_repeat = '0;
                wd_cnt       = 0;
                cycle_limit  = 0;
                cyc          = 0;
                align_cnt    = 0;
                rng_state    = 64'd8986;
                m_mode       = MODE_ALL;    // Breaker state after reset
                m_cfg_burst  = '0;
                m_cfg_period = '0;
                m_burst      = '0;
                m_period     = '0;
                m_repeat     = '0;
                for (int i = 0; i <= DEPTH; i++)
                        pipe[i] = '0;
                test_name    = "none";
                test_checks  = 0;
                test_errors  = 0;
                total_checks = 0;
                total_errors = 0;
                n_tests      = 0;
                stim_cycles  = 0;
                md           = MODE_ALL;
                b            = '0;
                p            = '0;
                r            = '0;

                fd = $fopen("verif/pcs_testdata.txt", "r");
                if (fd == 0)
                begin
                        $display("Cannot open the test data file verif/pcs_testdata.txt");
                        $display("TESTS FAILED");
                        $finish;
                end
                else
                begin
                        // First pass sizes the watchdog
                        while (!$feof(fd))
                        begin
                                line = "";
                                kind = "";
                                void'($fgets(line, fd));
                                void'($sscanf(line, "%s", kind));
                                if (kind == "C")
                                        stim_cycles++;
                                else if (kind == "B" &&
                                         $sscanf(line, "%s %d %d %s %d", kind, v, c, tok, n) == 5)
                                        stim_cycles += n;
                        end
                        $fclose(fd);
                        cycle_limit = stim_cycles + LATENCY + 20;

                        repeat (5) @(posedge i_clock);
                        i_reset <= 1'b0;

                        fd = $fopen("verif/pcs_testdata.txt", "r");
                        while (!$feof(fd))
                        begin
                                line = "";
                                kind = "";
                                void'($fgets(line, fd));
                                void'($sscanf(line, "%s", kind));
                                if (kind == "T")
                                begin
                                        void'($sscanf(line, "%s %s", kind, test_name));
                                        test_checks = 0;
                                        test_errors = 0;
                                end
                                else if (kind == "C")
                                begin
                                        void'($sscanf(line, "%s %h %d %d %d", kind, md, b, p, r));
                                        run_cycle(1'b0, 1'b0, '0, 1'b1, err_mode_t'(md), b, p, r);
                                end
                                else if (kind == "B")
                                begin
                                        void'($sscanf(line, "%s %d %d %s %d", kind, v, c, tok, n));
                                        for (int k = 0; k < n; k++)
                                        begin
                                                if (tok == "R")
                                                begin
                                                        rng_state = lcg_next(rng_state);
                                                        pl = rng_state;
                                                end
                                                else
                                                        void'($sscanf(tok, "%h", pl));
                                                run_cycle(v, c, pl, 1'b0, err_mode_t'(md), b, p, r);
                                        end
                                end
                                else if (kind == "E")
                                begin
                                        if (exp_q.size() != 0)
                                                report_error("blocks left in flight at the end");
                                        $display("%-20s %0d checks, %0d errors", test_name,
                                                 test_checks, test_errors);
                                        n_tests++;
                                        total_checks += test_checks;
                                        total_errors += test_errors;
                                end
                        end
                        $fclose(fd);

                        $display("%0d tests, %0d checks, %0d errors", n_tests, total_checks,
                                 total_errors);
                        if (total_errors == 0 && n_tests > 0)
                                $display("TESTS PASSED");
                        else
                                $display("TESTS FAILED");
                        $finish;
                end
        end

endmodule

`default_nettype wire
